/* src/glb_pkg.sv */
// ##############################
// global buffer sizes, vector types
// and address field helpers
// ##############################

package glb_pkg;

// tiles in the chain, tile 0 sits next to the host port
localparam int NUM_TILES = 4;

// tile field, upper bits of a word address
localparam int TILE_SEL_ADDR_WIDTH = 2;

// word address inside one bank, 256 words per tile
localparam int BANK_ADDR_WIDTH = 8;

// full word address
localparam int GLB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH;

// one data word
localparam int DATA_WIDTH = 32;

// tile number
typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;

// address within a bank
typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

// tile field + bank address
typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;

// data word
typedef logic [DATA_WIDTH-1:0] glb_data_t;

// tile that owns a word address
function automatic tile_id_t tile_of(input glb_addr_t addr);
    return addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];
endfunction

// word offset inside the owning bank
function automatic bank_addr_t bank_addr_of(input glb_addr_t addr);
    return addr[BANK_ADDR_WIDTH-1:0];
endfunction

endpackage

/* src/glb_tile_bank.sv */
// ##############################
// single-port tile memory bank
// ##############################

`timescale 1ns/100ps

module glb_tile_bank (
    input  logic                clk,
    input  logic                wen,
    input  logic                ren,
    input  glb_pkg::bank_addr_t addr,
    input  glb_pkg::glb_data_t  wdata,
    output glb_pkg::glb_data_t  rdata
);

// 256 words
glb_pkg::glb_data_t mem [2**glb_pkg::BANK_ADDR_WIDTH];

// write on the edge
always_ff @(posedge clk) begin
    if (wen) begin
        mem[addr] <= wdata;
    end
end

// registered read, data one cycle after ren
// holds its value when idle
always_ff @(posedge clk) begin
    if (ren) begin
        rdata <= mem[addr];
    end
end

endmodule

/* src/glb_tile_proc_router.sv */
// ##############################
// tile router, both packet directions
// plus local request / response taps
// ##############################

`timescale 1ns/100ps

module glb_tile_proc_router #(
    parameter glb_pkg::tile_id_t TILE_ID = '0
) (
    input  logic               clk,
    input  logic               reset,

    // eastbound, from west neighbor
    input  logic               wr_en_w2e_wsti,
    input  glb_pkg::glb_addr_t wr_addr_w2e_wsti,
    input  glb_pkg::glb_data_t wr_data_w2e_wsti,
    input  logic               rdrq_en_w2e_wsti,
    input  glb_pkg::glb_addr_t rdrq_addr_w2e_wsti,
    input  logic               rdrs_valid_w2e_wsti,
    input  glb_pkg::glb_data_t rdrs_data_w2e_wsti,

    // westbound, from east neighbor
    input  logic               wr_en_e2w_esti,
    input  glb_pkg::glb_addr_t wr_addr_e2w_esti,
    input  glb_pkg::glb_data_t wr_data_e2w_esti,
    input  logic               rdrq_en_e2w_esti,
    input  glb_pkg::glb_addr_t rdrq_addr_e2w_esti,
    input  logic               rdrs_valid_e2w_esti,
    input  glb_pkg::glb_data_t rdrs_data_e2w_esti,

    // eastbound, to east neighbor
    output logic               wr_en_w2e_esto,
    output glb_pkg::glb_addr_t wr_addr_w2e_esto,
    output glb_pkg::glb_data_t wr_data_w2e_esto,
    output logic               rdrq_en_w2e_esto,
    output glb_pkg::glb_addr_t rdrq_addr_w2e_esto,
    output logic               rdrs_valid_w2e_esto,
    output glb_pkg::glb_data_t rdrs_data_w2e_esto,

    // westbound, to west neighbor
    output logic               wr_en_e2w_wsto,
    output glb_pkg::glb_addr_t wr_addr_e2w_wsto,
    output glb_pkg::glb_data_t wr_data_e2w_wsto,
    output logic               rdrq_en_e2w_wsto,
    output glb_pkg::glb_addr_t rdrq_addr_e2w_wsto,
    output logic               rdrs_valid_e2w_wsto,
    output glb_pkg::glb_data_t rdrs_data_e2w_wsto,

    // local requests to the switch
    output logic               wr_en_pr2sw,
    output glb_pkg::glb_addr_t wr_addr_pr2sw,
    output glb_pkg::glb_data_t wr_data_pr2sw,
    output logic               rdrq_en_pr2sw,
    output glb_pkg::glb_addr_t rdrq_addr_pr2sw,

    // local response from the switch
    input  logic               rdrs_valid_sw2pr,
    input  glb_pkg::glb_data_t rdrs_data_sw2pr
);

// passing responses, one stage
logic               w2e_rdrs_valid_d1;
glb_pkg::glb_data_t w2e_rdrs_data_d1;
logic               e2w_rdrs_valid_d1;
glb_pkg::glb_data_t e2w_rdrs_data_d1;

// local response, one stage
logic               sw_rdrs_valid_d1;
glb_pkg::glb_data_t sw_rdrs_data_d1;

// packet valids
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        wr_en_w2e_esto    <= 1'b0;
        rdrq_en_w2e_esto  <= 1'b0;
        w2e_rdrs_valid_d1 <= 1'b0;
        wr_en_e2w_wsto    <= 1'b0;
        rdrq_en_e2w_wsto  <= 1'b0;
        e2w_rdrs_valid_d1 <= 1'b0;
        sw_rdrs_valid_d1  <= 1'b0;
    end else begin
        wr_en_w2e_esto    <= wr_en_w2e_wsti;
        rdrq_en_w2e_esto  <= rdrq_en_w2e_wsti;
        w2e_rdrs_valid_d1 <= rdrs_valid_w2e_wsti;
        wr_en_e2w_wsto    <= wr_en_e2w_esti;
        rdrq_en_e2w_wsto  <= rdrq_en_e2w_esti;
        e2w_rdrs_valid_d1 <= rdrs_valid_e2w_esti;
        sw_rdrs_valid_d1  <= rdrs_valid_sw2pr;
    end
end

// packet payloads
always_ff @(posedge clk) begin
    wr_addr_w2e_esto   <= wr_addr_w2e_wsti;
    wr_data_w2e_esto   <= wr_data_w2e_wsti;
    rdrq_addr_w2e_esto <= rdrq_addr_w2e_wsti;
    w2e_rdrs_data_d1   <= rdrs_data_w2e_wsti;
    wr_addr_e2w_wsto   <= wr_addr_e2w_esti;
    wr_data_e2w_wsto   <= wr_data_e2w_esti;
    rdrq_addr_e2w_wsto <= rdrq_addr_e2w_esti;
    e2w_rdrs_data_d1   <= rdrs_data_e2w_esti;
    sw_rdrs_data_d1    <= rdrs_data_sw2pr;
end

// even tiles serve the eastbound stream, odd tiles the westbound one
assign wr_en_pr2sw     = TILE_ID[0] ? wr_en_e2w_wsto : wr_en_w2e_esto;
assign wr_addr_pr2sw   = TILE_ID[0] ? wr_addr_e2w_wsto : wr_addr_w2e_esto;
assign wr_data_pr2sw   = TILE_ID[0] ? wr_data_e2w_wsto : wr_data_w2e_esto;
assign rdrq_en_pr2sw   = TILE_ID[0] ? rdrq_en_e2w_wsto : rdrq_en_w2e_esto;
assign rdrq_addr_pr2sw = TILE_ID[0] ? rdrq_addr_e2w_wsto : rdrq_addr_w2e_esto;

// local response replaces the passing one on both sides
assign rdrs_valid_w2e_esto = sw_rdrs_valid_d1 | w2e_rdrs_valid_d1;
assign rdrs_data_w2e_esto  = sw_rdrs_valid_d1 ? sw_rdrs_data_d1 : w2e_rdrs_data_d1;
assign rdrs_valid_e2w_wsto = sw_rdrs_valid_d1 | e2w_rdrs_valid_d1;
assign rdrs_data_e2w_wsto  = sw_rdrs_valid_d1 ? sw_rdrs_data_d1 : e2w_rdrs_data_d1;

// single read in flight, so no collision with a passing response
rdrs_no_collision: assert property (@(posedge clk) disable iff (reset)
    !(sw_rdrs_valid_d1 && (w2e_rdrs_valid_d1 || e2w_rdrs_valid_d1)))
    else $error("tile %0d: local and passing response collide", TILE_ID);

endmodule

/* src/glb_tile_proc_switch.sv */
// ##############################
// tile switch, address decode,
// bank access and read response
// ##############################

`timescale 1ns/100ps

module glb_tile_proc_switch #(
    parameter glb_pkg::tile_id_t TILE_ID = '0
) (
    input  logic                clk,
    input  logic                reset,

    // requests from the router
    input  logic                wr_en_pr2sw,
    input  glb_pkg::glb_addr_t  wr_addr_pr2sw,
    input  glb_pkg::glb_data_t  wr_data_pr2sw,
    input  logic                rdrq_en_pr2sw,
    input  glb_pkg::glb_addr_t  rdrq_addr_pr2sw,

    // response to the router
    output logic                rdrs_valid_sw2pr,
    output glb_pkg::glb_data_t  rdrs_data_sw2pr,

    // bank side
    output logic                mem_wen,
    output logic                mem_ren,
    output glb_pkg::bank_addr_t mem_addr,
    output glb_pkg::glb_data_t  mem_wdata,
    input  glb_pkg::glb_data_t  mem_rdata
);

// request owned by this tile
logic wr_hit;
logic rd_hit;

// read issued last cycle
logic mem_ren_d1;

// tile field compare
assign wr_hit = wr_en_pr2sw && (glb_pkg::tile_of(wr_addr_pr2sw) == TILE_ID);
assign rd_hit = rdrq_en_pr2sw && (glb_pkg::tile_of(rdrq_addr_pr2sw) == TILE_ID);

// same-cycle bank access
assign mem_wen   = wr_hit;
assign mem_ren   = rd_hit;
assign mem_wdata = wr_data_pr2sw;
// write and read never overlap, write wins the address port
assign mem_addr  = wr_hit ? glb_pkg::bank_addr_of(wr_addr_pr2sw)
                          : glb_pkg::bank_addr_of(rdrq_addr_pr2sw);

// response valid lines up with bank data
always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        mem_ren_d1 <= 1'b0;
    end else begin
        mem_ren_d1 <= rd_hit;
    end
end

assign rdrs_valid_sw2pr = mem_ren_d1;
// quiet data bus between responses
assign rdrs_data_sw2pr  = mem_ren_d1 ? mem_rdata : '0;

// host bridge keeps one transaction in the chain
wr_rd_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(wr_hit && rd_hit))
    else $error("tile %0d: owned write and read in one cycle", TILE_ID);

endmodule

/* src/glb_tile.sv */
// ##############################
// one tile, router + switch + bank
// ##############################

`timescale 1ns/100ps

module glb_tile #(
    parameter glb_pkg::tile_id_t TILE_ID = '0
) (
    input  logic               clk,
    input  logic               reset,

    // eastbound in
    input  logic               wr_en_w2e_wsti,
    input  glb_pkg::glb_addr_t wr_addr_w2e_wsti,
    input  glb_pkg::glb_data_t wr_data_w2e_wsti,
    input  logic               rdrq_en_w2e_wsti,
    input  glb_pkg::glb_addr_t rdrq_addr_w2e_wsti,
    input  logic               rdrs_valid_w2e_wsti,
    input  glb_pkg::glb_data_t rdrs_data_w2e_wsti,

    // westbound in
    input  logic               wr_en_e2w_esti,
    input  glb_pkg::glb_addr_t wr_addr_e2w_esti,
    input  glb_pkg::glb_data_t wr_data_e2w_esti,
    input  logic               rdrq_en_e2w_esti,
    input  glb_pkg::glb_addr_t rdrq_addr_e2w_esti,
    input  logic               rdrs_valid_e2w_esti,
    input  glb_pkg::glb_data_t rdrs_data_e2w_esti,

    // eastbound out
    output logic               wr_en_w2e_esto,
    output glb_pkg::glb_addr_t wr_addr_w2e_esto,
    output glb_pkg::glb_data_t wr_data_w2e_esto,
    output logic               rdrq_en_w2e_esto,
    output glb_pkg::glb_addr_t rdrq_addr_w2e_esto,
    output logic               rdrs_valid_w2e_esto,
    output glb_pkg::glb_data_t rdrs_data_w2e_esto,

    // westbound out
    output logic               wr_en_e2w_wsto,
    output glb_pkg::glb_addr_t wr_addr_e2w_wsto,
    output glb_pkg::glb_data_t wr_data_e2w_wsto,
    output logic               rdrq_en_e2w_wsto,
    output glb_pkg::glb_addr_t rdrq_addr_e2w_wsto,
    output logic               rdrs_valid_e2w_wsto,
    output glb_pkg::glb_data_t rdrs_data_e2w_wsto
);

// router to switch
logic                wr_en_pr2sw;
glb_pkg::glb_addr_t  wr_addr_pr2sw;
glb_pkg::glb_data_t  wr_data_pr2sw;
logic                rdrq_en_pr2sw;
glb_pkg::glb_addr_t  rdrq_addr_pr2sw;

// switch to router
logic                rdrs_valid_sw2pr;
glb_pkg::glb_data_t  rdrs_data_sw2pr;

// switch to bank
logic                mem_wen;
logic                mem_ren;
glb_pkg::bank_addr_t mem_addr;
glb_pkg::glb_data_t  mem_wdata;
glb_pkg::glb_data_t  mem_rdata;

// link and local ports share names with the tile
glb_tile_proc_router #(.TILE_ID(TILE_ID)) router_i (.*);

glb_tile_proc_switch #(.TILE_ID(TILE_ID)) switch_i (.*);

glb_tile_bank bank_i (
    .clk   (clk),
    .wen   (mem_wen),
    .ren   (mem_ren),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
);

endmodule

/* src/glb_host_bridge.sv */
// ##############################
// host port, four-phase req/ack
// to chain packets
// ##############################

`timescale 1ns/100ps

module glb_host_bridge (
    input  logic               clk,
    input  logic               reset,

    // host side
    input  logic               req,
    input  logic               we,
    input  glb_pkg::glb_addr_t addr,
    input  glb_pkg::glb_data_t wdata,
    output logic               ack,
    output glb_pkg::glb_data_t rdata,

    // eastbound into tile 0
    output logic               wr_en_w2e_esto,
    output glb_pkg::glb_addr_t wr_addr_w2e_esto,
    output glb_pkg::glb_data_t wr_data_w2e_esto,
    output logic               rdrq_en_w2e_esto,
    output glb_pkg::glb_addr_t rdrq_addr_w2e_esto,

    // westbound response out of tile 0
    input  logic               rdrs_valid,
    input  glb_pkg::glb_data_t rdrs_data
);

typedef enum logic [2:0] {
    st_idle,
    st_send,
    st_wait_rsp,
    st_done,
    st_release
} state_t;

state_t state;
state_t state_next;

// captured host request
logic               we_q;
glb_pkg::glb_addr_t addr_q;
glb_pkg::glb_data_t wdata_q;

always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
        state <= st_idle;
    end else begin
        state <= state_next;
    end
end

always_comb begin
    state_next = state;
    case (state)
        st_idle: begin
            if (req) begin
                state_next = st_send;
            end
        end
        // writes finish on launch
        st_send: state_next = we_q ? st_done : st_wait_rsp;
        // read latency depends on the owning tile
        st_wait_rsp: begin
            if (rdrs_valid) begin
                state_next = st_done;
            end
        end
        // ack high until host drops req
        st_done: begin
            if (!req) begin
                state_next = st_release;
            end
        end
        st_release: state_next = st_idle;
        default: state_next = st_idle;
    endcase
end

// request capture and read data latch
always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
        we_q    <= we;
        addr_q  <= addr;
        wdata_q <= wdata;
    end
    if (state == st_wait_rsp && rdrs_valid) begin
        rdata <= rdrs_data;
    end
end

// one-cycle packet in send
assign wr_en_w2e_esto     = (state == st_send) && we_q;
assign wr_addr_w2e_esto   = addr_q;
assign wr_data_w2e_esto   = wdata_q;
assign rdrq_en_w2e_esto   = (state == st_send) && !we_q;
assign rdrq_addr_w2e_esto = addr_q;

assign ack = (state == st_done);

// host must keep req up until it sees ack
req_held: assert property (@(posedge clk) disable iff (reset)
    (state == st_send || state == st_wait_rsp) |-> req)
    else $error("host dropped req before ack");

endmodule

/* src/glb_top.sv */
// ##############################
// global buffer top, host bridge
// and four-tile chain
// ##############################

`timescale 1ns/100ps

module glb_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               we,
    input  glb_pkg::glb_addr_t addr,
    input  glb_pkg::glb_data_t wdata,
    output logic               ack,
    output glb_pkg::glb_data_t rdata
);

// eastbound links, index k enters tile k from the west
logic               e_wr_en      [glb_pkg::NUM_TILES+1];
glb_pkg::glb_addr_t e_wr_addr    [glb_pkg::NUM_TILES+1];
glb_pkg::glb_data_t e_wr_data    [glb_pkg::NUM_TILES+1];
logic               e_rdrq_en    [glb_pkg::NUM_TILES+1];
glb_pkg::glb_addr_t e_rdrq_addr  [glb_pkg::NUM_TILES+1];
logic               e_rdrs_valid [glb_pkg::NUM_TILES+1];
glb_pkg::glb_data_t e_rdrs_data  [glb_pkg::NUM_TILES+1];

// westbound links, index k leaves tile k to the west
logic               w_wr_en      [glb_pkg::NUM_TILES+1];
glb_pkg::glb_addr_t w_wr_addr    [glb_pkg::NUM_TILES+1];
glb_pkg::glb_data_t w_wr_data    [glb_pkg::NUM_TILES+1];
logic               w_rdrq_en    [glb_pkg::NUM_TILES+1];
glb_pkg::glb_addr_t w_rdrq_addr  [glb_pkg::NUM_TILES+1];
logic               w_rdrs_valid [glb_pkg::NUM_TILES+1];
glb_pkg::glb_data_t w_rdrs_data  [glb_pkg::NUM_TILES+1];

glb_host_bridge bridge_i (
    .*,
    .wr_en_w2e_esto     (e_wr_en[0]),
    .wr_addr_w2e_esto   (e_wr_addr[0]),
    .wr_data_w2e_esto   (e_wr_data[0]),
    .rdrq_en_w2e_esto   (e_rdrq_en[0]),
    .rdrq_addr_w2e_esto (e_rdrq_addr[0]),
    .rdrs_valid         (w_rdrs_valid[0]),
    .rdrs_data          (w_rdrs_data[0])
);

// bridge never injects a response
assign e_rdrs_valid[0] = 1'b0;
assign e_rdrs_data[0]  = '0;

// east end turn-around, requests only
assign w_wr_en[glb_pkg::NUM_TILES]      = e_wr_en[glb_pkg::NUM_TILES];
assign w_wr_addr[glb_pkg::NUM_TILES]    = e_wr_addr[glb_pkg::NUM_TILES];
assign w_wr_data[glb_pkg::NUM_TILES]    = e_wr_data[glb_pkg::NUM_TILES];
assign w_rdrq_en[glb_pkg::NUM_TILES]    = e_rdrq_en[glb_pkg::NUM_TILES];
assign w_rdrq_addr[glb_pkg::NUM_TILES]  = e_rdrq_addr[glb_pkg::NUM_TILES];
// eastbound response copy ends here
assign w_rdrs_valid[glb_pkg::NUM_TILES] = 1'b0;
assign w_rdrs_data[glb_pkg::NUM_TILES]  = '0;

for (genvar i = 0; i < glb_pkg::NUM_TILES; i++) begin : gen_tile
    glb_tile #(
        .TILE_ID(glb_pkg::tile_id_t'(i))
    ) tile_i (
        .clk                 (clk),
        .reset               (reset),
        .wr_en_w2e_wsti      (e_wr_en[i]),
        .wr_addr_w2e_wsti    (e_wr_addr[i]),
        .wr_data_w2e_wsti    (e_wr_data[i]),
        .rdrq_en_w2e_wsti    (e_rdrq_en[i]),
        .rdrq_addr_w2e_wsti  (e_rdrq_addr[i]),
        .rdrs_valid_w2e_wsti (e_rdrs_valid[i]),
        .rdrs_data_w2e_wsti  (e_rdrs_data[i]),
        .wr_en_e2w_esti      (w_wr_en[i+1]),
        .wr_addr_e2w_esti    (w_wr_addr[i+1]),
        .wr_data_e2w_esti    (w_wr_data[i+1]),
        .rdrq_en_e2w_esti    (w_rdrq_en[i+1]),
        .rdrq_addr_e2w_esti  (w_rdrq_addr[i+1]),
        .rdrs_valid_e2w_esti (w_rdrs_valid[i+1]),
        .rdrs_data_e2w_esti  (w_rdrs_data[i+1]),
        .wr_en_w2e_esto      (e_wr_en[i+1]),
        .wr_addr_w2e_esto    (e_wr_addr[i+1]),
        .wr_data_w2e_esto    (e_wr_data[i+1]),
        .rdrq_en_w2e_esto    (e_rdrq_en[i+1]),
        .rdrq_addr_w2e_esto  (e_rdrq_addr[i+1]),
        .rdrs_valid_w2e_esto (e_rdrs_valid[i+1]),
        .rdrs_data_w2e_esto  (e_rdrs_data[i+1]),
        .wr_en_e2w_wsto      (w_wr_en[i]),
        .wr_addr_e2w_wsto    (w_wr_addr[i]),
        .wr_data_e2w_wsto    (w_wr_data[i]),
        .rdrq_en_e2w_wsto    (w_rdrq_en[i]),
        .rdrq_addr_e2w_wsto  (w_rdrq_addr[i]),
        .rdrs_valid_e2w_wsto (w_rdrs_valid[i]),
        .rdrs_data_e2w_wsto  (w_rdrs_data[i])
    );
end

endmodule

/* testbench/glb_tb.sv */
// ##############################
// global buffer testbench, host driver,
// reference model, compare, watchdog
// ##############################

`timescale 1ns/100ps

module glb_tb;

// clock and run length
localparam int CLK_PERIOD_NS = 4;
localparam int RESET_CYCLES = 3;
localparam int ACK_LIMIT = 32;
localparam int DROP_LIMIT = 8;
localparam int RANDOM_OPS = 300;
localparam int MEM_WORDS = 2**glb_pkg::GLB_ADDR_WIDTH;
// host transactions over all tests
localparam int NUM_OPS = 4 * glb_pkg::NUM_TILES + 3 + MEM_WORDS + RANDOM_OPS + 2;
localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
localparam logic [31:0] SEED = 32'hbed69a43;

logic               clk;
logic               reset;
logic               req;
logic               we;
glb_pkg::glb_addr_t addr;
glb_pkg::glb_data_t wdata;
logic               ack;
glb_pkg::glb_data_t rdata;

// reference memory, whole address space
glb_pkg::glb_data_t model_mem [MEM_WORDS];

// issued transactions, oldest first
logic               pend_we   [$];
glb_pkg::glb_addr_t pend_addr [$];
glb_pkg::glb_data_t pend_data [$];

int   error_count = 0;
int   check_count = 0;
logic ack_prev = 1'b0;

glb_top dut_i (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
end

// expected result of one host access, model updated on writes
function automatic glb_pkg::glb_data_t reference_access(
    input logic               op_we,
    input glb_pkg::glb_addr_t op_addr,
    input glb_pkg::glb_data_t op_wdata
);
    if (op_we) begin
        model_mem[op_addr] = op_wdata;
    end
    return model_mem[op_addr];
endfunction

// wrong value
task automatic record_mismatch(input string msg);
    $display("[FAIL] t=%0t: %s", $time, msg);
    error_count++;
endtask

// handshake or protocol problem
task automatic record_problem(input string msg);
    $display("handshake error at t=%0t: %s", $time, msg);
    error_count++;
endtask

task automatic report_test(input int num, input string name, input int errors_before);
    if (error_count == errors_before) begin
        $display("test %0d %s: ok", num, name);
    end else begin
        $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
    end
endtask

// one four-phase transaction, req held hold_cycles past ack
task automatic host_access(
    input logic               op_we,
    input glb_pkg::glb_addr_t op_addr,
    input glb_pkg::glb_data_t op_wdata,
    input int                 hold_cycles
);
    glb_pkg::glb_data_t expected;
    int                 waited;
    expected = reference_access(op_we, op_addr, op_wdata);
    pend_we.push_back(op_we);
    pend_addr.push_back(op_addr);
    pend_data.push_back(expected);
    @(negedge clk);
    req   = 1'b1;
    we    = op_we;
    addr  = op_addr;
    wdata = op_wdata;
    waited = 0;
    while (!ack && waited < ACK_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    check_count++;
    assert (ack) else record_problem($sformatf("no ack for access to %h", op_addr));
    // ack must stay up as long as req does
    for (int i = 0; i < hold_cycles; i++) begin
        @(negedge clk);
        check_count++;
        assert (ack) else record_problem("ack dropped while req still high");
    end
    req = 1'b0;
    waited = 0;
    while (ack && waited < DROP_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    check_count++;
    assert (!ack) else record_problem("ack stayed high after req fell");
endtask

// compare on each rising ack, outputs stable at the falling edge
always @(negedge clk) begin : compare_proc
    logic               exp_we;
    glb_pkg::glb_addr_t exp_addr;
    glb_pkg::glb_data_t exp_data;
    if (ack && !ack_prev) begin
        assert (pend_addr.size() > 0) else record_problem("ack without a pending request");
        if (pend_addr.size() > 0) begin
            exp_we   = pend_we.pop_front();
            exp_addr = pend_addr.pop_front();
            exp_data = pend_data.pop_front();
            // rdata only means something on reads
            if (!exp_we) begin
                check_count++;
                assert (rdata == exp_data) else record_mismatch($sformatf(
                    "read %h returned %h, expected %h", exp_addr, rdata, exp_data));
            end
        end
    end
    ack_prev = ack;
end

initial begin : stimulus
    int                 errors_before;
    glb_pkg::glb_addr_t a;
    glb_pkg::glb_data_t d;
    logic               w;
    void'($urandom(SEED));
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // quiet host port
    errors_before = error_count;
    repeat (10) begin
        @(negedge clk);
        check_count++;
        assert (!ack) else record_problem("ack high with req low after reset");
    end
    report_test(1, "idle after reset", errors_before);

    // one word per tile, even and odd owners
    errors_before = error_count;
    for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
        a = {glb_pkg::tile_id_t'(t), glb_pkg::bank_addr_t'(8'h3c + t)};
        d = glb_pkg::glb_data_t'($urandom());
        host_access(1'b1, a, d, 1);
        host_access(1'b0, a, '0, 1);
    end
    report_test(2, "write then read in each tile", errors_before);

    // second write wins
    errors_before = error_count;
    a = 10'h2a7;
    host_access(1'b1, a, 32'h1111_2222, 1);
    host_access(1'b1, a, 32'h3333_4444, 1);
    host_access(1'b0, a, '0, 1);
    report_test(3, "double write then read", errors_before);

    // back to back write and read, no extra hold
    errors_before = error_count;
    for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
        a = {glb_pkg::tile_id_t'(t), glb_pkg::bank_addr_t'(8'hf0 - t)};
        d = glb_pkg::glb_data_t'($urandom());
        host_access(1'b1, a, d, 0);
        host_access(1'b0, a, '0, 0);
    end
    report_test(4, "write directly followed by read", errors_before);

    // fill pattern built from the whole address
    errors_before = error_count;
    for (int i = 0; i < MEM_WORDS; i++) begin
        a = glb_pkg::glb_addr_t'(i);
        host_access(1'b1, a, {12'h5a3, a, ~a}, 0);
    end
    // random mix over all tiles
    for (int n = 0; n < RANDOM_OPS; n++) begin
        w = $urandom_range(1, 0) == 1;
        a = glb_pkg::glb_addr_t'($urandom_range(MEM_WORDS - 1, 0));
        d = glb_pkg::glb_data_t'($urandom());
        host_access(w, a, d, 1);
    end
    report_test(5, "fill and random mix", errors_before);

    // long req hold, then no stray ack
    errors_before = error_count;
    host_access(1'b1, 10'h155, 32'hcafe_0155, 5);
    host_access(1'b0, 10'h155, '0, 5);
    repeat (8) begin
        @(negedge clk);
        check_count++;
        assert (!ack) else record_problem("second ack without a new req");
    end
    check_count++;
    assert (pend_addr.size() == 0) else record_problem("transactions left without ack");
    report_test(6, "four-phase handshake", errors_before);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

// bound on the whole run
initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
    $display("watchdog timeout after %0d cycles, simulation stopped", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
end

endmodule

/* flist.f */
src/glb_pkg.sv
src/glb_tile_bank.sv
src/glb_tile_proc_router.sv
src/glb_tile_proc_switch.sv
src/glb_tile.sv
src/glb_host_bridge.sv
src/glb_top.sv
testbench/glb_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the global buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f flist.f --top-module glb_tb \
    --Mdir "$BUILD" -o glb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile step returned an error"
    exit 1
fi

"./$BUILD/glb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
